// File: design/mem_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DDR and AXI geometry for a 256-bit bus with fixed 16-beat INCR bursts
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package mem_pkg;

    localparam int unsigned ADDR_W    = 15 + 3 + 10;   // row + bank + column
    localparam int unsigned DATA_W    = 256;
    localparam int unsigned STRB_W    = 32;            // one strobe per byte
    localparam int unsigned BURST_LEN = 16;
    localparam int unsigned ADDR_STEP = 128;           // controller addresses per burst

    localparam logic [3:0] AW_LEN        = 4'd15;      // BURST_LEN - 1
    localparam logic [2:0] AW_SIZE       = 3'd5;       // 32 bytes per beat
    localparam logic [1:0] AW_BURST_INCR = 2'b01;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [3:0]        beat_t;

endpackage

`default_nettype wire

// File: design/chan_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// four channels, each owning two frame slots in one contiguous region
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package chan_pkg;

    localparam int unsigned NUM_CH       = 4;
    localparam int unsigned FRAME_OFFSET = 30000;
    localparam int unsigned CH_REGION    = 2 * FRAME_OFFSET;   // two slots per channel

    typedef logic [1:0]        ch_t;
    typedef logic [NUM_CH-1:0] ch_mask_t;

    typedef enum logic [1:0] {
        PAUSE = 2'd0,   // parked at rotation boundary
        SCAN  = 2'd1,
        ADDR  = 2'd2,
        DATA  = 2'd3
    } sched_state_t;

endpackage

`default_nettype wire

// File: design/sched_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// grant and burst progress pulses, one burst in flight at a time
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

interface sched_if
    import chan_pkg::*;
();

    ch_t  ch_sel;       // held until burst_done
    logic addr_start;
    logic aw_done;
    logic burst_done;

    modport sched (output ch_sel, output addr_start, input aw_done, input burst_done);
    modport addr  (input ch_sel, input addr_start, output aw_done);
    modport data  (input ch_sel, input aw_done, output burst_done);

endinterface

`default_nettype wire

// File: design/frame_tracker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// vsync may be asynchronous; outputs lag its rise by two clock edges
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module frame_tracker
    import chan_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  ch_mask_t  vsync,
    output ch_mask_t  armed,
    output ch_mask_t  frame_sel,
    output ch_mask_t  new_frame
);

    ch_mask_t vs_s1;
    ch_mask_t vs_s2;
    ch_mask_t vs_rise;

    assign vs_rise = vs_s1 & ~vs_s2;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            vs_s1     <= '0;
            vs_s2     <= '0;
            armed     <= '0;
            frame_sel <= '0;
            new_frame <= '0;
        end else begin
            vs_s1     <= vsync;
            vs_s2     <= vs_s1;
            new_frame <= vs_rise;
            armed     <= armed | vs_rise;
            // first edge lands on slot 0, then ping-pong
            frame_sel <= (frame_sel ^ (vs_rise & armed)) & (armed | ~vs_rise);
        end
    end

    a_frame_pulse: assert property (@(posedge clk) disable iff (!rst)
        ~|(new_frame & $past(new_frame)));

endmodule

`default_nettype wire

// File: design/burst_scheduler.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// round robin, one channel looked at per cycle; starts parked in PAUSE
// processing_wait is only honoured at the end of a full rotation
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module burst_scheduler
    import chan_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  ch_mask_t  armed,
    input  ch_mask_t  rready,
    input  wire logic processing_wait,
    output logic      wait_proceed,
    sched_if.sched    sif
);

    sched_state_t state;
    ch_t          idx;
    logic         last_ch;
    logic         take;
    logic         step;     // move on to the next index

    assign last_ch    = (idx == ch_t'(NUM_CH - 1));
    assign take       = armed[idx] && rready[idx];
    assign step       = ((state == SCAN) && !take) || ((state == DATA) && sif.burst_done);
    assign sif.ch_sel = idx;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state          <= PAUSE;
            sif.addr_start <= 1'b0;
        end else begin
            sif.addr_start <= 1'b0;
            case (state)
                PAUSE: begin
                    if (!processing_wait)
                        state <= SCAN;
                end
                SCAN: begin
                    if (take) begin
                        state          <= ADDR;
                        sif.addr_start <= 1'b1;
                    end
                end
                ADDR: begin
                    if (sif.aw_done)
                        state <= DATA;
                end
                default: ;  // DATA leaves through step
            endcase
            if (step)
                state <= (last_ch && processing_wait) ? PAUSE : SCAN;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst)
            idx <= '0;
        else if (step)
            idx <= last_ch ? ch_t'(0) : idx + ch_t'(1);
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst)
            wait_proceed <= 1'b0;
        else
            wait_proceed <= (state == PAUSE) && processing_wait;
    end

    // grant must hold while the other two engines work on it
    a_grant_hold: assert property (@(posedge clk) disable iff (!rst)
        (state inside {ADDR, DATA}) |-> $stable(sif.ch_sel));

endmodule

`default_nettype wire

// File: design/burst_addr_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// line offsets are not bounded; a frame must fit inside its slot
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module burst_addr_gen
    import mem_pkg::*;
    import chan_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  ch_mask_t  new_frame,
    input  ch_mask_t  frame_sel,
    sched_if.addr     sif,
    output addr_t     awaddr,
    output logic      awvalid,
    input  wire logic awready
);

    addr_t line_off [NUM_CH];
    addr_t cur_off;
    addr_t slot_off;
    logic  aw_hs;

    assign aw_hs       = awvalid && awready;
    assign sif.aw_done = aw_hs;

    // a frame restart in the same cycle already counts as offset zero
    assign cur_off  = new_frame[sif.ch_sel] ? '0 : line_off[sif.ch_sel];
    assign slot_off = frame_sel[sif.ch_sel] ? addr_t'(FRAME_OFFSET) : '0;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < NUM_CH; i++)
                line_off[i] <= '0;
        end else begin
            for (int i = 0; i < NUM_CH; i++) begin
                if (new_frame[i])
                    line_off[i] <= '0;
                else if (aw_hs && (sif.ch_sel == ch_t'(i)))
                    line_off[i] <= line_off[i] + addr_t'(ADDR_STEP);
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst)
            awvalid <= 1'b0;
        else if (sif.addr_start)
            awvalid <= 1'b1;
        else if (awready)
            awvalid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (sif.addr_start)
            awaddr <= addr_t'(CH_REGION) * addr_t'(sif.ch_sel) + slot_off + cur_off;
    end

    a_aw_stable: assert property (@(posedge clk) disable iff (!rst)
        (awvalid && !awready) |=> $stable(awaddr));

endmodule

`default_nettype wire

// File: design/burst_data_path.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// wdata and rd_en are combinational; buffers must be show-ahead
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module burst_data_path
    import mem_pkg::*;
    import chan_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    sched_if.data     sif,
    input  data_t     ch_data [NUM_CH],
    output ch_mask_t  rd_en,
    output data_t     wdata,
    output logic      wvalid,
    output logic      wlast,
    input  wire logic wready
);

    beat_t beat;
    logic  w_hs;

    assign w_hs           = wvalid && wready;
    assign sif.burst_done = w_hs && wlast;
    assign wdata          = ch_data[sif.ch_sel];
    assign rd_en          = w_hs ? (ch_mask_t'(1) << sif.ch_sel) : '0;   // granted buffer only

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wvalid <= 1'b0;
            wlast  <= 1'b0;
            beat   <= '0;
        end else if (sif.aw_done) begin
            wvalid <= 1'b1;
            wlast  <= 1'b0;
            beat   <= '0;
        end else if (w_hs) begin
            if (wlast) begin
                wvalid <= 1'b0;
                wlast  <= 1'b0;
            end else begin
                beat  <= beat + beat_t'(1);
                wlast <= (beat == beat_t'(BURST_LEN - 2));   // next beat is the last
            end
        end
    end

    a_wlast_valid: assert property (@(posedge clk) disable iff (!rst)
        wlast |-> wvalid);

endmodule

`default_nettype wire

// File: design/buf_to_ddr_writer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AW and W only; write responses are accepted and ignored (bready high)
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module buf_to_ddr_writer
    import mem_pkg::*;
    import chan_pkg::*;
(
    input  wire logic         clk,
    input  wire logic         rst,
    input  ch_mask_t          ch_vsync,
    input  ch_mask_t          ch_rready,
    input  data_t             ch_data [NUM_CH],
    output ch_mask_t          ch_rd_en,
    input  wire logic         processing_wait,
    output logic              wait_proceed,
    output addr_t             axi_awaddr,
    output logic [3:0]        axi_awid,
    output logic [3:0]        axi_awlen,
    output logic [2:0]        axi_awsize,
    output logic [1:0]        axi_awburst,
    output logic              axi_awvalid,
    input  wire logic         axi_awready,
    output data_t             axi_wdata,
    output logic [STRB_W-1:0] axi_wstrb,
    output logic              axi_wlast,
    output logic              axi_wvalid,
    input  wire logic         axi_wready,
    output logic              axi_bready
);

    ch_mask_t armed;
    ch_mask_t frame_sel;
    ch_mask_t new_frame;

    sched_if sif ();

    assign axi_awid    = 4'd0;
    assign axi_awlen   = AW_LEN;
    assign axi_awsize  = AW_SIZE;
    assign axi_awburst = AW_BURST_INCR;
    assign axi_wstrb   = {STRB_W{1'b1}};   // full beats only
    assign axi_bready  = 1'b1;

    frame_tracker u_frame_tracker (
        .clk       (clk),
        .rst       (rst),
        .vsync     (ch_vsync),
        .armed     (armed),
        .frame_sel (frame_sel),
        .new_frame (new_frame)
    );

    burst_scheduler u_burst_scheduler (
        .clk             (clk),
        .rst             (rst),
        .armed           (armed),
        .rready          (ch_rready),
        .processing_wait (processing_wait),
        .wait_proceed    (wait_proceed),
        .sif             (sif.sched)
    );

    burst_addr_gen u_burst_addr_gen (
        .clk       (clk),
        .rst       (rst),
        .new_frame (new_frame),
        .frame_sel (frame_sel),
        .sif       (sif.addr),
        .awaddr    (axi_awaddr),
        .awvalid   (axi_awvalid),
        .awready   (axi_awready)
    );

    burst_data_path u_burst_data_path (
        .clk     (clk),
        .rst     (rst),
        .sif     (sif.data),
        .ch_data (ch_data),
        .rd_en   (ch_rd_en),
        .wdata   (axi_wdata),
        .wvalid  (axi_wvalid),
        .wlast   (axi_wlast),
        .wready  (axi_wready)
    );

endmodule

`default_nettype wire

// File: tb/tb_buf_to_ddr_writer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// table rows start from the parked scheduler; vsync is only pulsed there
// AXI slave readies are random, so burst latency varies from run to run
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_buf_to_ddr_writer
    import mem_pkg::*;
    import chan_pkg::*;
();

    localparam int unsigned CLK_PERIOD      = 40;
    localparam int unsigned SEED            = 32'h9889c4cd;
    localparam int unsigned NUM_ROWS        = 7;
    localparam int unsigned MAX_BURSTS      = 8;
    localparam int unsigned HOLD_CYCLES     = 20;
    localparam int unsigned WATCHDOG_CYCLES = NUM_ROWS * MAX_BURSTS * BURST_LEN * 8;

    // order holds channel k of the row in bits [2k+1:2k]
    string       row_name   [NUM_ROWS] = '{"single_ch0", "all_armed", "skip_not_ready",
                                           "hold_paused", "new_frame", "third_frame",
                                           "ch3_only"};
    ch_mask_t    row_vsync  [NUM_ROWS] = '{4'b0001, 4'b1110, 4'b0000, 4'b0000,
                                           4'b0101, 4'b0001, 4'b1000};
    ch_mask_t    row_rready [NUM_ROWS] = '{4'b1111, 4'b1111, 4'b1010, 4'b1111,
                                           4'b0111, 4'b1101, 4'b1000};
    logic        row_wait   [NUM_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
    int unsigned row_count  [NUM_ROWS] = '{3, 8, 4, 0, 6, 6, 2};
    logic [15:0] row_ord    [NUM_ROWS] = '{16'h0000, 16'hE4E4, 16'h00DD, 16'h0000,
                                           16'h0924, 16'h0E38, 16'h000F};

    logic              clk = 1'b0;
    logic              rst;
    ch_mask_t          ch_vsync;
    ch_mask_t          ch_rready;
    data_t             ch_data [NUM_CH] = '{default: '0};
    ch_mask_t          ch_rd_en;
    logic              processing_wait;
    logic              wait_proceed;
    addr_t             axi_awaddr;
    logic [3:0]        axi_awid;
    logic [3:0]        axi_awlen;
    logic [2:0]        axi_awsize;
    logic [1:0]        axi_awburst;
    logic              axi_awvalid;
    logic              axi_awready = 1'b0;
    data_t             axi_wdata;
    logic [STRB_W-1:0] axi_wstrb;
    logic              axi_wlast;
    logic              axi_wvalid;
    logic              axi_wready = 1'b0;
    logic              axi_bready;

    // reference model written by the main process only
    bit          m_armed      [NUM_CH] = '{default: 1'b0};
    int unsigned m_slot       [NUM_CH] = '{default: 0};
    int unsigned m_frame_base [NUM_CH] = '{default: 0};   // bursts seen at last vsync
    // monitor bookkeeping written by the monitor only
    int unsigned aw_per_ch    [NUM_CH] = '{default: 0};
    int unsigned fifo_pos     [NUM_CH] = '{default: 0};   // beats popped via rd_en
    int unsigned data_pos     [NUM_CH] = '{default: 0};   // beats accepted on W
    int unsigned aws_seen    = 0;
    int unsigned bursts_done = 0;
    int unsigned beat        = 0;
    ch_t         cur_ch      = '0;
    logic        aw_hold     = 1'b0;
    addr_t       held_addr   = '0;
    // current row
    string       cur_name    = "reset_idle";
    int unsigned row_aw_base = 0;
    int unsigned row_bursts  = 0;
    logic [15:0] row_order   = '0;

    buf_to_ddr_writer dut (
        .clk             (clk),
        .rst             (rst),
        .ch_vsync        (ch_vsync),
        .ch_rready       (ch_rready),
        .ch_data         (ch_data),
        .ch_rd_en        (ch_rd_en),
        .processing_wait (processing_wait),
        .wait_proceed    (wait_proceed),
        .axi_awaddr      (axi_awaddr),
        .axi_awid        (axi_awid),
        .axi_awlen       (axi_awlen),
        .axi_awsize      (axi_awsize),
        .axi_awburst     (axi_awburst),
        .axi_awvalid     (axi_awvalid),
        .axi_awready     (axi_awready),
        .axi_wdata       (axi_wdata),
        .axi_wstrb       (axi_wstrb),
        .axi_wlast       (axi_wlast),
        .axi_wvalid      (axi_wvalid),
        .axi_wready      (axi_wready),
        .axi_bready      (axi_bready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_mismatch(input string what, input logic [255:0] exp,
                                   input logic [255:0] act);
        $display("FAIL %s: %s expected %0h, got %0h", cur_name, what, exp, act);
        $display("Done: errors found");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic report_error(input string what);
        $display("ERROR in %s: %s", cur_name, what);
        $display("Done: errors found");
        $fatal(1, "stopped at the first error");
    endtask

    // slave readies and show-ahead buffer heads
    always @(negedge clk) begin
        axi_awready = ($urandom % 4) != 0;
        axi_wready  = ($urandom % 4) != 0;
        for (int c = 0; c < NUM_CH; c++)
            ch_data[c] = {8'(c), 248'(fifo_pos[c])};
    end

    always @(posedge clk) begin
        ch_t         ch;
        ch_t         aw_ch;
        int unsigned k;
        addr_t       exp_addr;
        data_t       exp_data;
        ch_mask_t    exp_rd;
        logic [12:0] exp_fields;   // awid, awlen, awsize, awburst
        if (rst) begin
            exp_rd = (axi_wvalid && axi_wready) ? (4'b0001 << cur_ch) : 4'b0000;
            assert (ch_rd_en == exp_rd)
                else report_mismatch("rd_en", 256'(exp_rd), 256'(ch_rd_en));
            assert (!(wait_proceed && axi_awvalid)) else report_error("awvalid high while parked");
            assert (axi_bready) else report_error("bready low after reset");
            if (aw_hold) begin
                assert (axi_awvalid) else report_error("awvalid dropped before awready");
                assert (axi_awaddr == held_addr)
                    else report_mismatch("held awaddr", 256'(held_addr), 256'(axi_awaddr));
            end
            if (axi_awvalid && axi_awready) begin
                k = aws_seen - row_aw_base;
                assert (k < row_bursts) else report_error("more bursts than the row expects");
                assert (bursts_done == aws_seen) else report_error("address before burst end");
                ch = ch_t'(row_order >> (2 * k));
                aw_ch = ch_t'(axi_awaddr / CH_REGION);   // channel region the DUT wrote to
                assert (m_armed[aw_ch] && ch_rready[aw_ch])
                    else report_error("burst granted to an unarmed or not ready channel");
                exp_addr = addr_t'(32'(ch) * CH_REGION + m_slot[ch] * FRAME_OFFSET
                                   + (aw_per_ch[ch] - m_frame_base[ch]) * ADDR_STEP);
                assert (axi_awaddr == exp_addr)
                    else report_mismatch("awaddr", 256'(exp_addr), 256'(axi_awaddr));
                exp_fields = {4'd0, 4'(BURST_LEN - 1), 3'($clog2(DATA_W / 8)), 2'b01};  // INCR
                assert ({axi_awid, axi_awlen, axi_awsize, axi_awburst} == exp_fields)
                    else report_mismatch("awid/awlen/awsize/awburst", 256'(exp_fields),
                                         256'({axi_awid, axi_awlen, axi_awsize, axi_awburst}));
                cur_ch        = ch;
                aw_per_ch[ch] = aw_per_ch[ch] + 1;
                aws_seen      = aws_seen + 1;
                beat          = 0;
            end
            if (axi_wvalid && axi_wready) begin
                assert (bursts_done < aws_seen) else report_error("data beat with no address");
                exp_data = {8'(cur_ch), 248'(data_pos[cur_ch])};
                assert (axi_wdata == exp_data) else report_mismatch("wdata", exp_data, axi_wdata);
                assert (axi_wstrb == {STRB_W{1'b1}})
                    else report_mismatch("wstrb", 256'({STRB_W{1'b1}}), 256'(axi_wstrb));
                assert (axi_wlast == (beat == BURST_LEN - 1))
                    else report_mismatch("wlast", 256'(beat == BURST_LEN - 1), 256'(axi_wlast));
                data_pos[cur_ch] = data_pos[cur_ch] + 1;
                if (beat == BURST_LEN - 1) begin
                    bursts_done = bursts_done + 1;
                    beat        = 0;
                end else begin
                    beat = beat + 1;
                end
            end
            for (int c = 0; c < NUM_CH; c++)
                if (ch_rd_en[c])
                    fifo_pos[c] = fifo_pos[c] + 1;
            aw_hold   = axi_awvalid && !axi_awready;
            held_addr = axi_awaddr;
        end
    end

    task automatic wait_parked();
        while (!wait_proceed)
            @(negedge clk);
    endtask

    // model first since the DUT only sees the edge two clocks later
    task automatic apply_vsync(input ch_mask_t mask);
        for (int c = 0; c < NUM_CH; c++) begin
            if (mask[c]) begin
                m_slot[c]       = m_armed[c] ? 1 - m_slot[c] : 0;
                m_armed[c]      = 1'b1;
                m_frame_base[c] = aw_per_ch[c];
            end
        end
        ch_vsync = mask;
        repeat (2) @(negedge clk);
        ch_vsync = '0;
        repeat (4) @(negedge clk);
    endtask

    task automatic run_row(input int unsigned r);
        cur_name    = row_name[r];
        row_aw_base = aws_seen;
        row_order   = row_ord[r];
        apply_vsync(row_vsync[r]);
        ch_rready       = row_rready[r];
        row_bursts      = row_count[r];
        processing_wait = row_wait[r];
        if (row_wait[r]) begin
            repeat (HOLD_CYCLES) begin
                @(negedge clk);
                assert (wait_proceed && !axi_awvalid) else report_error("pause not held");
            end
        end else begin
            @(negedge clk);
            assert (!wait_proceed) else report_error("wait_proceed stuck high after release");
            while (aws_seen - row_aw_base < row_bursts)
                @(negedge clk);
            processing_wait = 1'b1;   // rotation ends with the last expected burst
            wait_parked();
            assert (bursts_done == aws_seen) else report_error("parked with a burst in flight");
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rst             = 1'b0;
        ch_vsync        = '0;
        ch_rready       = '0;
        processing_wait = 1'b0;
        repeat (10) @(negedge clk);
        rst = 1'b1;
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            assert (!axi_awvalid && !axi_wvalid && !axi_wlast && ch_rd_en == '0 && !wait_proceed)
                else report_error("outputs active with no channel armed");
        end
        processing_wait = 1'b1;
        wait_parked();
        for (int unsigned r = 0; r < NUM_ROWS; r++)
            run_row(r);
        $display("Done: no errors");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        report_error("timeout, the DUT stopped making progress");
    end

endmodule

`default_nettype wire

// File: build.f
design/mem_pkg.sv
design/chan_pkg.sv
design/sched_if.sv
design/frame_tracker.sv
design/burst_scheduler.sv
design/burst_addr_gen.sv
design/burst_data_path.sv
design/buf_to_ddr_writer.sv
tb/tb_buf_to_ddr_writer.sv

// File: run.sh
#!/usr/bin/env bash
# compile with Verilator, run the testbench, judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f \
    --top-module tb_buf_to_ddr_writer -Mdir obj_dir -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "Done: no errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
